// File: src/mem_cfg_pkg.sv
// Data memory geometry
package mem_cfg_pkg;

  // width of one data word in bits
  localparam int unsigned DATA_WIDTH = 32;

  // one write enable per byte of the data word
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // each cut is a 1024 by 32 macro with an 8 bit row and 2 bit column address
  localparam int unsigned CUT_WORDS      = 1024;
  localparam int unsigned ROW_WIDTH      = 8;
  localparam int unsigned COL_WIDTH      = 2;
  localparam int unsigned CUT_ADDR_WIDTH = ROW_WIDTH + COL_WIDTH;

  // five cuts need three select bits, so indices 5 to 7 name nothing
  localparam int unsigned N_CUTS        = 5;
  localparam int unsigned CUT_SEL_WIDTH = 3;

  // full word address seen on the request port
  localparam int unsigned ADDR_WIDTH = 13;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [CUT_ADDR_WIDTH-1:0] cut_addr_t;
  typedef logic [CUT_SEL_WIDTH-1:0]  cut_sel_t;

  // the word address split the way the banks see it
  // the cut index sits on top, row and column form the address inside the cut
  typedef struct packed {
    cut_sel_t               cut;
    logic [ROW_WIDTH-1:0]   row;
    logic [COL_WIDTH-1:0]   col;
  } mem_addr_split_t;

  // one address word, read either as a flat index or as cut, row and column
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    mem_addr_split_t       split;
  } mem_addr_u;

endpackage

// File: src/mem_bus_pkg.sv
// Memory port and cut command types
package mem_bus_pkg;

  // one access on the request port
  // req marks a valid cycle, we selects a write, be picks the written bytes
  typedef struct packed {
    logic                  req;
    logic                  we;
    mem_cfg_pkg::mem_addr_u addr;
    mem_cfg_pkg::data_t    wdata;
    mem_cfg_pkg::strb_t    be;
  } mem_req_t;

  // command broadcast to every cut
  // only the cut whose enable is raised acts on it
  typedef struct packed {
    logic                  we;
    mem_cfg_pkg::cut_addr_t addr;
    mem_cfg_pkg::data_t    wdata;
    mem_cfg_pkg::strb_t    be;
  } cut_cmd_t;

endpackage

// File: src/sram_cut.sv
// Single memory cut
`timescale 1ns/10ps

module sram_cut (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_i,
  input  mem_bus_pkg::cut_cmd_t cmd_i,
  output mem_cfg_pkg::data_t    rdata_o
);

  // behavioral model of one 1024 word macro
  mem_cfg_pkg::data_t mem_q [mem_cfg_pkg::CUT_WORDS];

  logic wr_en;
  logic rd_en;

  assign wr_en = en_i & cmd_i.we;
  assign rd_en = en_i & ~cmd_i.we;

  // byte granular write, bytes with a cleared enable keep their contents
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < mem_cfg_pkg::STRB_WIDTH; b++) begin
        if (cmd_i.be[b]) begin
          mem_q[cmd_i.addr][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read port register, loaded only by a read and held otherwise
  // starts at zero so the memory output is defined before the first read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      rdata_o <= mem_q[cmd_i.addr];
    end
  end

endmodule

// File: src/tcdm_ctrl.sv
// Banked memory control
`timescale 1ns/10ps

module tcdm_ctrl (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  mem_bus_pkg::mem_req_t                           req_i,
  input  mem_cfg_pkg::data_t [mem_cfg_pkg::N_CUTS-1:0]    cut_rdata_i,
  output mem_bus_pkg::cut_cmd_t                           cmd_o,
  output logic [mem_cfg_pkg::N_CUTS-1:0]                  cut_en_o,
  output mem_cfg_pkg::data_t                              rdata_o,
  output logic                                            rvalid_o,
  output logic                                            err_o
);

  mem_cfg_pkg::cut_sel_t req_cut;
  logic                  in_range;
  logic                  rd_req;

  // registered read state used one cycle after the request
  mem_cfg_pkg::cut_sel_t rd_sel_q;
  logic                  rd_zero_q;
  logic                  rvalid_q;
  logic                  err_q;

  assign req_cut  = req_i.addr.split.cut;
  assign in_range = req_cut < mem_cfg_pkg::cut_sel_t'(mem_cfg_pkg::N_CUTS);
  assign rd_req   = req_i.req & ~req_i.we;

  // the cut command is the same for all banks
  // row and column together address a word inside the cut
  always_comb begin
    cmd_o.we    = req_i.we;
    cmd_o.addr  = {req_i.addr.split.row, req_i.addr.split.col};
    cmd_o.wdata = req_i.wdata;
    cmd_o.be    = req_i.be;
  end

  // raise the one enable whose index matches the cut field
  // an index past the last cut leaves every bank idle, so nothing is written
  always_comb begin
    cut_en_o = '0;
    for (int i = 0; i < mem_cfg_pkg::N_CUTS; i++) begin
      if (req_i.req && in_range && (req_cut == mem_cfg_pkg::cut_sel_t'(i))) begin
        cut_en_o[i] = 1'b1;
      end
    end
  end

  // remember which cut answers the read and whether the answer is zero
  // the selection is only updated by reads, so rdata_o holds between them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_sel_q  <= '0;
      rd_zero_q <= 1'b0;
    end else if (rd_req) begin
      if (in_range) begin
        rd_sel_q  <= req_cut;
        rd_zero_q <= 1'b0;
      end else begin
        // keep the old select, the zero flag masks it anyway
        rd_zero_q <= 1'b1;
      end
    end
  end

  // response strobes are single cycle pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
      err_q    <= req_i.req & ~in_range;
    end
  end

  // the cut output registers were loaded on the same edge as rd_sel_q
  assign rdata_o  = rd_zero_q ? '0 : cut_rdata_i[rd_sel_q];
  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

// File: src/tcdm_top.sv
// Banked data memory top
`timescale 1ns/10ps

module tcdm_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_bus_pkg::mem_req_t req_i,
  output mem_cfg_pkg::data_t    rdata_o,
  output logic                  rvalid_o,
  output logic                  err_o
);

  // command shared by all cuts, with one enable per cut
  mem_bus_pkg::cut_cmd_t                        cmd;
  logic [mem_cfg_pkg::N_CUTS-1:0]               cut_en;
  mem_cfg_pkg::data_t [mem_cfg_pkg::N_CUTS-1:0] cut_rdata;

  tcdm_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .cut_rdata_i (cut_rdata),
    .cmd_o       (cmd),
    .cut_en_o    (cut_en),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o),
    .err_o       (err_o)
  );

  // cut i holds word addresses i*1024 to i*1024+1023
  for (genvar i = 0; i < mem_cfg_pkg::N_CUTS; i++) begin : g_cut
    sram_cut u_cut (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (cut_en[i]),
      .cmd_i   (cmd),
      .rdata_o (cut_rdata[i])
    );
  end

endmodule

// File: test/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset is held for three rising edges and released off the edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

// File: test/tcdm_sva.sv
// Control block assertions
`timescale 1ns/10ps

module tcdm_sva (
  input logic                           clk_i,
  input logic                           rst_ni,
  input mem_bus_pkg::mem_req_t          req_i,
  input logic [mem_cfg_pkg::N_CUTS-1:0] cut_en_o,
  input mem_cfg_pkg::data_t             rdata_o,
  input logic                           rvalid_o,
  input logic                           err_o
);

  logic rd_req;
  logic bad_addr;

  assign rd_req   = req_i.req & ~req_i.we;
  assign bad_addr = req_i.addr.split.cut >= mem_cfg_pkg::cut_sel_t'(mem_cfg_pkg::N_CUTS);

  // at most one bank is touched per cycle
  en_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(cut_en_o))
    else $error("cut enables are not one-hot");

  // an address past the last cut must leave every bank idle
  en_bad_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.req && bad_addr) |-> (cut_en_o == '0))
    else $error("cut enabled for an address out of range");

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req |=> rvalid_o)
    else $error("read request not answered one cycle later");

  rvalid_only_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_req |=> !rvalid_o)
    else $error("rvalid_o raised without a read request");

  // the first edge out of reset still sees the reset values
  reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!rvalid_o && !err_o && (rdata_o == '0)))
    else $error("outputs not cleared by reset");

endmodule

bind tcdm_ctrl tcdm_sva u_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .cut_en_o (cut_en_o),
  .rdata_o  (rdata_o),
  .rvalid_o (rvalid_o),
  .err_o    (err_o)
);

// File: test/tcdm_tb.sv
// Banked memory testbench
`timescale 1ns/10ps

module tcdm_tb;

  logic                  clk;
  logic                  rst_n;
  mem_bus_pkg::mem_req_t req;
  mem_cfg_pkg::data_t    rdata;
  logic                  rvalid;
  logic                  err;

  // reference image of all 5120 words
  mem_cfg_pkg::data_t model_mem [mem_cfg_pkg::N_CUTS * mem_cfg_pkg::CUT_WORDS];
  mem_cfg_pkg::data_t last_rd;
  logic [31:0]        lfsr_q;
  int                 err_cnt;
  int                 chk_cnt;
  int                 test_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_top u_dut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (req),
    .rdata_o  (rdata),
    .rvalid_o (rvalid),
    .err_o    (err)
  );

  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic mem_cfg_pkg::mem_addr_u cut_word(input int cut, input int idx);
    mem_cfg_pkg::mem_addr_u a;
    a.split.cut = mem_cfg_pkg::cut_sel_t'(cut);
    {a.split.row, a.split.col} = mem_cfg_pkg::cut_addr_t'(idx);
    return a;
  endfunction

  // only the first 5120 word addresses exist
  function automatic logic in_range(input mem_cfg_pkg::mem_addr_u a);
    return 32'(a.flat) < (mem_cfg_pkg::N_CUTS * mem_cfg_pkg::CUT_WORDS);
  endfunction

  function automatic void model_write(input mem_cfg_pkg::mem_addr_u a,
                                      input mem_cfg_pkg::data_t d,
                                      input mem_cfg_pkg::strb_t be);
    if (in_range(a)) begin
      for (int b = 0; b < mem_cfg_pkg::STRB_WIDTH; b++) begin
        if (be[b]) begin
          model_mem[a.flat][b*8 +: 8] = d[b*8 +: 8];
        end
      end
    end
  endfunction

  function automatic mem_cfg_pkg::data_t model_read(input mem_cfg_pkg::mem_addr_u a);
    return in_range(a) ? model_mem[a.flat] : '0;
  endfunction

  function automatic mem_bus_pkg::mem_req_t make_req(input logic we,
                                                      input mem_cfg_pkg::mem_addr_u a,
                                                      input mem_cfg_pkg::data_t d,
                                                      input mem_cfg_pkg::strb_t be);
    mem_bus_pkg::mem_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = a;
    r.wdata = d;
    r.be    = be;
    return r;
  endfunction

  task automatic check_data(input string name, input mem_cfg_pkg::data_t got,
                            input mem_cfg_pkg::data_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  // inputs change 10 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic finish_test(input string name, input int start);
    test_cnt++;
    if (err_cnt == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - start);
    end
  endtask

  task automatic idle_cycle();
    req = '0;
    step();
    check_flag("rvalid_o", rvalid, 1'b0);
    check_flag("err_o", err, 1'b0);
    check_data("rdata_o", rdata, last_rd);
  endtask

  task automatic do_write(input mem_cfg_pkg::mem_addr_u a, input mem_cfg_pkg::data_t d,
                          input mem_cfg_pkg::strb_t be);
    req = make_req(1'b1, a, d, be);
    step();
    req = '0;
    model_write(a, d, be);
    check_flag("err_o", err, !in_range(a));
    check_flag("rvalid_o", rvalid, 1'b0);
  endtask

  task automatic do_read(input mem_cfg_pkg::mem_addr_u a);
    mem_cfg_pkg::data_t exp;
    int                 n;
    exp = model_read(a);
    req = make_req(1'b0, a, '0, '0);
    step();
    req = '0;
    n = 0;
    while (!rvalid && n < 20) begin
      step();
      n++;
    end
    if (!rvalid) begin
      $display("read of word 0x%h got no rvalid_o within 20 cycles", a.flat);
      err_cnt++;
    end else begin
      if (n != 0) begin
        $display("read of word 0x%h answered %0d cycles late", a.flat, n);
        err_cnt++;
      end
      check_data("rdata_o", rdata, exp);
      check_flag("err_o", err, !in_range(a));
      last_rd = exp;
    end
  endtask

  task automatic test_reset();
    int start;
    int n;
    start = err_cnt;
    n = 0;
    while (!rst_n && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("reset was not released within 10 cycles");
      err_cnt++;
    end
    #10;
    check_flag("rvalid_o", rvalid, 1'b0);
    check_flag("err_o", err, 1'b0);
    check_data("rdata_o", rdata, '0);
    finish_test("reset state", start);
  endtask

  // every word gets a pattern built from its own address
  task automatic fill_memory();
    mem_cfg_pkg::mem_addr_u a;
    for (int i = 0; i < mem_cfg_pkg::N_CUTS * mem_cfg_pkg::CUT_WORDS; i++) begin
      a.flat = mem_cfg_pkg::ADDR_WIDTH'(i);
      do_write(a, {a.flat, ~a.flat, a.flat[5:0]}, 4'hf);
    end
  endtask

  task automatic test_full_words();
    int start;
    start = err_cnt;
    for (int c = 0; c < mem_cfg_pkg::N_CUTS; c++) begin
      do_write(cut_word(c, 0), rand_bits(32), 4'hf);
      do_read(cut_word(c, 0));
      do_write(cut_word(c, 1023), rand_bits(32), 4'hf);
      do_read(cut_word(c, 1023));
    end
    finish_test("full-word writes and reads", start);
  endtask

  task automatic test_byte_merge();
    mem_cfg_pkg::strb_t     masks [5];
    mem_cfg_pkg::mem_addr_u a;
    int                     start;
    start = err_cnt;
    masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
    for (int k = 0; k < 2; k++) begin
      a = (k == 0) ? cut_word(2, 77) : cut_word(4, 513);
      do_write(a, rand_bits(32), 4'hf);
      do_read(a);
      foreach (masks[m]) begin
        do_write(a, rand_bits(32), masks[m]);
        do_read(a);
      end
    end
    finish_test("byte-enable merging", start);
  endtask

  // a new read is taken in the same cycle the previous one is answered
  task automatic test_back_to_back();
    mem_cfg_pkg::mem_addr_u addrs [8];
    mem_cfg_pkg::data_t     exp_q [8];
    logic [31:0]            r;
    int                     start;
    start = err_cnt;
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(10);
      addrs[i] = cut_word(i % 5, int'(r[9:0]));
      exp_q[i] = model_read(addrs[i]);
    end
    for (int i = 0; i < 8; i++) begin
      if (i > 0) begin
        check_flag("rvalid_o", rvalid, 1'b1);
        check_data("rdata_o", rdata, exp_q[i-1]);
      end
      req = make_req(1'b0, addrs[i], '0, '0);
      step();
    end
    req = '0;
    check_flag("rvalid_o", rvalid, 1'b1);
    check_data("rdata_o", rdata, exp_q[7]);
    last_rd = exp_q[7];
    repeat (3) idle_cycle();
    finish_test("back-to-back reads", start);
  endtask

  task automatic test_out_of_range();
    logic [31:0] r;
    int          start;
    int          idx;
    start = err_cnt;
    for (int c = mem_cfg_pkg::N_CUTS; c < 8; c++) begin
      r = rand_bits(10);
      idx = int'(r[9:0]);
      do_write(cut_word(c, idx), rand_bits(32), 4'hf);
      do_read(cut_word(c, idx));
      // the same row and column in real cuts must be untouched
      for (int k = 0; k < mem_cfg_pkg::N_CUTS; k++) begin
        do_read(cut_word(k, idx));
      end
    end
    finish_test("out-of-range accesses", start);
  endtask

  task automatic test_random();
    mem_cfg_pkg::mem_addr_u a;
    logic [31:0]            r;
    int                     start;
    start = err_cnt;
    for (int n = 0; n < 200; n++) begin
      r = rand_bits(13);
      a.flat = r[mem_cfg_pkg::ADDR_WIDTH-1:0];
      r = rand_bits(2);
      if (r[1:0] == 2'd0) begin
        idle_cycle();
      end else if (r[1:0] == 2'd1) begin
        do_write(a, rand_bits(32), mem_cfg_pkg::strb_t'(rand_bits(4)));
      end else begin
        do_read(a);
      end
    end
    finish_test("random mixed traffic", start);
  endtask

  initial begin
    req      = '0;
    lfsr_q   = 32'hfaa1a73b;
    last_rd  = '0;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;

    test_reset();
    fill_memory();
    test_full_words();
    test_byte_merge();
    test_back_to_back();
    test_out_of_range();
    test_random();

    $display("tests run %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tcdm_top.f
src/mem_cfg_pkg.sv
src/mem_bus_pkg.sv
src/sram_cut.sv
src/tcdm_ctrl.sv
src/tcdm_top.sv
test/tb_clk_gen.sv
test/tcdm_sva.sv
test/tcdm_tb.sv

// File: Makefile
LOG := sim.log

sim:
	verilator --binary --timing --assert -f tcdm_top.f --top-module tcdm_tb -Mdir obj_dir
	./obj_dir/Vtcdm_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
